// File: bench/exec_input.txt
// Hex columns: a b opcode size preset_eflags expected_result expected_eflags
// Opcodes ADD=0 ADC=1 SUB=2 AND=3 OR=4 XOR=5 SHL=6 DAA=7, sizes 8=0 16=1 32=2
0000007f 00000001 0 0 00000000 00000080 00000890
000000ff 00000001 0 0 00000000 00000000 00000055
00008000 00008000 0 1 00000400 00000000 00000c45
7fffffff 00000001 0 2 00000000 80000000 00000894
0000000e 00000001 1 0 00000001 00000010 00000010
ffffffff 00000000 1 2 00000401 00000000 00000455
00000000 00000001 2 0 00000000 000000ff 00000095
00008000 00000001 2 1 00000000 00007fff 00000814
12345678 12345678 2 2 00000c95 00000000 00000444
ffff00f0 0000ff3c 3 0 ffffffff 00000030 00000404
00008000 00000001 4 1 00000000 00008001 00000080
a5a5a5a5 a5a5a5a5 5 2 00000811 00000000 00000044
000000c1 00000000 6 0 00000000 00000082 00000085
00004000 00000000 6 1 00000000 00008000 00000884
80000000 00000000 6 2 00000000 00000000 00000845
000000ae 00000000 7 0 00000000 00000014 00000015
00000012 00000000 7 0 00000010 00000018 00000014
00000040 00000000 7 0 00000001 000000a0 00000085

// File: x86_exec.f
design/x86_alu_pkg.sv
design/eflags_pkg.sv
design/alu_flag_if.sv
design/x86_alu.sv
design/flag_logic.sv
design/wb_exec_regs.sv
design/x86_exec_top.sv
bench/x86_exec_tb.sv

// File: Bender.yml
package:
  name: x86_exec

sources:
  # Packages first, then the interface and the modules that use them
  - files:
      - design/x86_alu_pkg.sv
      - design/eflags_pkg.sv
      - design/alu_flag_if.sv
      - design/x86_alu.sv
      - design/flag_logic.sv
      - design/wb_exec_regs.sv
      - design/x86_exec_top.sv

  - target: test
    files:
      - bench/x86_exec_tb.sv

// File: bench/x86_exec_tb.sv
//----------------------------------------------------------------------
// Testbench for the execute unit
// Wishbone read and write tasks, vector file replay, result and flag checks
//----------------------------------------------------------------------
`default_nettype none

module x86_exec_tb;
	import x86_alu_pkg::*;
	import eflags_pkg::*;

	localparam int ACK_TIMEOUT = 20;

	logic        clk;
	logic        reset;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [2:0]  wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic        wb_ack;
	int          mismatches;
	int          timeouts;
	int          other_errors;
	int          vectors;

	x86_exec_top dut (
		.clk      (clk),
		.reset    (reset),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	//------------------------------------------------------------------
	// Bus access
	//------------------------------------------------------------------
	// One classic cycle, ack and data sampled on the falling edge
	task automatic bus_cycle(input logic write, input logic [2:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int waited;
		waited = 0;
		rdata  = '0;
		@(posedge clk);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= write;
		wb_adr   <= addr;
		wb_dat_w <= wdata;
		@(negedge clk);
		while (!wb_ack && waited < ACK_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (wb_ack) begin
			rdata = wb_dat_r;
		end else begin
			$display("Timeout: no ack for address %0d after %0d cycles", addr, waited);
			timeouts++;
		end
		// Drop the strobe right on the ack edge
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic wb_write(input logic [2:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		bus_cycle(1'b1, addr, data, unused);
	endtask

	task automatic wb_read(input logic [2:0] addr, output logic [31:0] data);
		bus_cycle(1'b0, addr, 32'd0, data);
	endtask

	//------------------------------------------------------------------
	// Checks
	//------------------------------------------------------------------
	function automatic arith_flags_t to_flags(input logic [31:0] word);
		arith_flags_t f;
		f.cf = word[FLAG_CF];
		f.pf = word[FLAG_PF];
		f.af = word[FLAG_AF];
		f.zf = word[FLAG_ZF];
		f.sf = word[FLAG_SF];
		f.of = word[FLAG_OF];
		return f;
	endfunction

	task automatic check_result(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at time %0t: %s got %h expected %h", $time, what, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_flags(input arith_flags_t got, input logic got_df,
		input arith_flags_t exp, input logic exp_df, input string what);
		if ({got, got_df} !== {exp, exp_df}) begin
			$display("Mismatch at time %0t: %s got OF SF ZF AF PF CF DF = %b %b expected %b %b",
				$time, what, got, got_df, exp, exp_df);
			mismatches++;
		end
	endtask

	// Preset EFLAGS, launch, then read both result registers back
	task automatic run_vector(input logic [31:0] a, input logic [31:0] b, input logic [31:0] op,
		input logic [31:0] size, input logic [31:0] preset, input logic [31:0] exp_res,
		input logic [31:0] exp_fl, input int idx);
		logic [31:0] got_res;
		logic [31:0] got_fl;
		wb_write(REG_OPA, a);
		wb_write(REG_OPB, b);
		wb_write(REG_EFLAGS, preset);
		wb_write(REG_CMD, {26'd0, size[1:0], 1'b0, op[2:0]});
		wb_read(REG_RESULT, got_res);
		wb_read(REG_EFLAGS, got_fl);
		check_result(got_res, exp_res, $sformatf("vector %0d result", idx));
		check_flags(to_flags(got_fl), got_fl[FLAG_DF], to_flags(exp_fl), exp_fl[FLAG_DF],
			$sformatf("vector %0d flags", idx));
		check_result(got_fl & ~EFLAGS_MASK, 32'd0, $sformatf("vector %0d unused EFLAGS", idx));
	endtask

	//------------------------------------------------------------------
	// Main sequence
	//------------------------------------------------------------------
	initial begin
		int          fd;
		int          n;
		string       line;
		logic [31:0] got;
		logic [31:0] va;
		logic [31:0] vb;
		logic [31:0] vop;
		logic [31:0] vsize;
		logic [31:0] vpre;
		logic [31:0] vres;
		logic [31:0] vfl;
		mismatches   = 0;
		timeouts     = 0;
		other_errors = 0;
		vectors      = 0;
		reset    = 1'b1;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = 3'd0;
		wb_dat_w = 32'd0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;

		wb_read(REG_RESULT, got);
		check_result(got, 32'd0, "RESULT after reset");
		wb_read(REG_EFLAGS, got);
		check_result(got, 32'd0, "EFLAGS after reset");

		// Only the seven implemented bits stick
		wb_write(REG_EFLAGS, 32'hffff_ffff);
		wb_read(REG_EFLAGS, got);
		check_result(got, 32'h0000_0cd5, "EFLAGS masked readback");
		// ADD of zero operands, DF has to stay
		wb_write(REG_CMD, 32'd0);
		wb_read(REG_EFLAGS, got);
		check_flags(to_flags(got), got[FLAG_DF], to_flags(32'h0000_0044), 1'b1, "DF after ADD");

		fd = $fopen("bench/exec_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open the vector file bench/exec_input.txt");
			other_errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 0) begin
					n = $sscanf(line, "%h %h %h %h %h %h %h", va, vb, vop, vsize, vpre,
						vres, vfl);
				end
				// Comment and blank lines fail the scan
				if (n == 7) begin
					vectors++;
					run_vector(va, vb, vop, vsize, vpre, vres, vfl, vectors);
				end
			end
			$fclose(fd);
			if (vectors == 0) begin
				$display("The vector file held no usable vectors");
				other_errors++;
			end
		end

		$display("Vectors: %0d, mismatches: %0d, timeouts: %0d, other errors: %0d",
			vectors, mismatches, timeouts, other_errors);
		if (mismatches + timeouts + other_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: design/x86_exec_top.sv
//--------------------------------------------------------------------
// Execute unit top level with plain Wishbone ports
//--------------------------------------------------------------------
`default_nettype none

module x86_exec_top (
	input  logic        clk,
	input  logic        reset,
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  logic [2:0]  wb_adr,
	input  logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic        wb_ack
);
	import x86_alu_pkg::*;
	import eflags_pkg::*;

	logic [31:0]  opa;
	logic [31:0]  opb;
	logic [31:0]  result;
	alu_op_e      op;
	data_size_e   size;
	logic         cf_in;
	logic         af_in;
	arith_flags_t flags;

	// Datapath to flag logic bundle
	alu_flag_if u_alu_flag ();

	wb_exec_regs u_regs (
		.clk       (clk),
		.reset     (reset),
		.cyc       (wb_cyc),
		.stb       (wb_stb),
		.we        (wb_we),
		.adr       (wb_adr),
		.dat_w     (wb_dat_w),
		.dat_r     (wb_dat_r),
		.ack       (wb_ack),
		.opa       (opa),
		.opb       (opb),
		.op        (op),
		.size      (size),
		.cf_in     (cf_in),
		.af_in     (af_in),
		.result_in (result),
		.flags_in  (flags)
	);

	x86_alu u_alu (
		.a      (opa),
		.b      (opb),
		.op     (op),
		.size   (size),
		.cf_in  (cf_in),
		.af_in  (af_in),
		.result (result),
		.af     (u_alu_flag.alu_src)
	);

	flag_logic u_flags (
		.af    (u_alu_flag.flag_sink),
		.flags (flags)
	);

endmodule

`default_nettype wire

// File: design/wb_exec_regs.sv
//--------------------------------------------------------------------
// Wishbone classic slave with operand and command registers
// Holds the RESULT and EFLAGS registers of the execute unit
//--------------------------------------------------------------------
`default_nettype none

module wb_exec_regs (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      cyc,
	input  logic                      stb,
	input  logic                      we,
	input  logic [2:0]                adr,
	input  logic [31:0]               dat_w,
	output logic [31:0]               dat_r,
	output logic                      ack,
	output logic [31:0]               opa,
	output logic [31:0]               opb,
	output x86_alu_pkg::alu_op_e      op,
	output x86_alu_pkg::data_size_e   size,
	output logic                      cf_in,
	output logic                      af_in,
	input  logic [31:0]               result_in,
	input  eflags_pkg::arith_flags_t  flags_in
);
	import x86_alu_pkg::*;
	import eflags_pkg::*;

	typedef enum logic {WB_IDLE, WB_ACK} wb_state_e;

	wb_state_e   state;
	logic        wr_en;
	logic        launch;
	logic [1:0]  size_code;
	logic [31:0] result_q;
	logic [31:0] eflags_q;

	//----------------------------------------------------------------
	// Ack FSM
	//----------------------------------------------------------------
	// One ack per strobe, then wait for stb low
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= WB_IDLE;
			ack   <= 1'b0;
		end else begin
			ack <= 1'b0;
			case (state)
				WB_IDLE: if (cyc && stb) begin
					ack   <= 1'b1;
					state <= WB_ACK;
				end
				WB_ACK: if (!(cyc && stb)) state <= WB_IDLE;
				default: state <= WB_IDLE;
			endcase
		end
	end

	// Writes land on the ack edge
	assign wr_en     = ack & cyc & stb & we;
	assign size_code = dat_w[5:4];

	//----------------------------------------------------------------
	// Register file
	//----------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			opa      <= '0;
			opb      <= '0;
			op       <= ADD;
			size     <= SIZE_8;
			result_q <= '0;
			eflags_q <= '0;
			launch   <= 1'b0;
		end else begin
			// Command write fires the operation one cycle later
			launch <= wr_en && (adr == REG_CMD);
			if (wr_en) begin
				case (adr)
					REG_OPA: opa <= dat_w;
					REG_OPB: opb <= dat_w;
					REG_CMD: begin
						op   <= alu_op_e'(dat_w[2:0]);
						size <= (size_code == 2'd3) ? SIZE_32 : data_size_e'(size_code);
					end
					REG_EFLAGS: eflags_q <= dat_w & EFLAGS_MASK;
					default: ;
				endcase
			end
			if (launch) begin
				result_q          <= result_in;
				// DF left alone
				eflags_q[FLAG_CF] <= flags_in.cf;
				eflags_q[FLAG_PF] <= flags_in.pf;
				eflags_q[FLAG_AF] <= flags_in.af;
				eflags_q[FLAG_ZF] <= flags_in.zf;
				eflags_q[FLAG_SF] <= flags_in.sf;
				eflags_q[FLAG_OF] <= flags_in.of;
			end
		end
	end

	// Incoming flags for ADC and DAA
	assign cf_in = eflags_q[FLAG_CF];
	assign af_in = eflags_q[FLAG_AF];

	// Read mux, unmapped words give zero
	always_comb begin
		case (adr)
			REG_OPA:    dat_r = opa;
			REG_OPB:    dat_r = opb;
			REG_CMD:    dat_r = {26'd0, size, 1'b0, op};
			REG_RESULT: dat_r = result_q;
			REG_EFLAGS: dat_r = eflags_q;
			default:    dat_r = '0;
		endcase
	end

	ack_in_cycle: assert property (@(posedge clk) disable iff (reset) ack |-> cyc && stb)
		else $error("ack outside an active bus cycle");
	ack_single: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
		else $error("ack held for two cycles");

endmodule

`default_nettype wire

// File: design/flag_logic.sv
//--------------------------------------------------------------------
// Arithmetic flag generation selected by data size
// Covers CF OF SF ZF PF AF and the DAA special cases
//--------------------------------------------------------------------
`default_nettype none

module flag_logic (
	alu_flag_if.flag_sink        af,
	output eflags_pkg::arith_flags_t flags
);
	import x86_alu_pkg::*;

	logic msb_res;
	logic msb_a;
	logic msb_b;
	logic carry_out;
	logic shl_next;
	logic zero_span;
	logic daa_zero;
	logic parity;
	logic b_sign;
	logic arith_of;
	logic shl_of;

	//----------------------------------------------------------------
	// Per size bit picks
	//----------------------------------------------------------------
	always_comb begin
		case (af.size)
			SIZE_8: begin
				msb_res   = af.result[7];
				msb_a     = af.a[7];
				msb_b     = af.b[7];
				carry_out = af.carry[7];
				shl_next  = af.a[6];
				zero_span = (af.result[7:0] == 8'h00);
			end
			SIZE_16: begin
				msb_res   = af.result[15];
				msb_a     = af.a[15];
				msb_b     = af.b[15];
				carry_out = af.carry[15];
				shl_next  = af.a[14];
				zero_span = (af.result[15:0] == 16'h0000);
			end
			default: begin
				msb_res   = af.result[31];
				msb_a     = af.a[31];
				msb_b     = af.b[31];
				carry_out = af.carry[31];
				shl_next  = af.a[30];
				zero_span = (af.result == 32'd0);
			end
		endcase
	end

	// Even parity of low byte
	assign parity   = ~^af.result[7:0];
	// DAA only looks at AL
	assign daa_zero = (af.result[7:0] == 8'h00);

	// Signed overflow on add path, b seen inverted for SUB
	assign b_sign   = (af.op == SUB) ? ~msb_b : msb_b;
	assign arith_of = (msb_a == b_sign) & (msb_res != msb_a);
	// Top two operand bits differ
	assign shl_of   = msb_a ^ shl_next;

	//----------------------------------------------------------------
	// Per opcode overrides
	//----------------------------------------------------------------
	always_comb begin
		flags.sf = msb_res;
		flags.zf = zero_span;
		flags.pf = parity;
		flags.cf = carry_out;
		// Carry into bit 4
		flags.af = af.carry[3];
		flags.of = arith_of;
		case (af.op)
			AND, OR, XOR: begin
				flags.cf = 1'b0;
				flags.of = 1'b0;
				flags.af = 1'b0;
			end
			SHL: begin
				flags.of = shl_of;
				flags.af = 1'b0;
			end
			DAA: begin
				flags.cf = af.daa_cf;
				flags.af = af.daa_af;
				flags.of = 1'b0;
				flags.zf = daa_zero;
			end
			default: ;
		endcase
	end

	// Register block remaps code 3 before it reaches the datapath
	size_legal: assert final (af.size != 2'd3)
		else $error("reserved data size reached the flag logic");

endmodule

`default_nettype wire

// File: design/x86_alu.sv
//--------------------------------------------------------------------
// Integer datapath for ADD ADC SUB AND OR XOR SHL and DAA
//--------------------------------------------------------------------
`default_nettype none

module x86_alu (
	input  logic [31:0]             a,
	input  logic [31:0]             b,
	input  x86_alu_pkg::alu_op_e    op,
	input  x86_alu_pkg::data_size_e size,
	input  logic                    cf_in,
	input  logic                    af_in,
	output logic [31:0]             result,
	alu_flag_if.alu_src             af
);
	import x86_alu_pkg::*;

	logic [31:0] b_eff;
	logic        cin;
	logic [32:0] sum33;
	// Carry into each bit, bit 32 is the final carry out
	logic [32:0] cin_vec;
	logic [31:0] res_raw;
	logic [31:0] carry_vec;
	logic [31:0] size_mask;
	logic        lo_adj;
	logic        hi_adj;
	logic [7:0]  al_adj;

	//----------------------------------------------------------------
	// Shared adder
	//----------------------------------------------------------------
	// Subtract as a + ~b + 1
	assign b_eff = (op == SUB) ? ~b : b;
	assign cin   = (op == SUB) | ((op == ADC) & cf_in);
	assign sum33 = {1'b0, a} + {1'b0, b_eff} + {32'd0, cin};
	// Recover per-bit carries from the sum
	assign cin_vec = {1'b0, a} ^ {1'b0, b_eff} ^ sum33;

	// DAA on AL with the Intel adjust rule
	assign lo_adj = (a[3:0] > 4'd9) | af_in;
	assign hi_adj = (a[7:0] > 8'h99) | cf_in;
	assign al_adj = a[7:0] + (lo_adj ? 8'h06 : 8'h00) + (hi_adj ? 8'h60 : 8'h00);

	//----------------------------------------------------------------
	// Result and carry select
	//----------------------------------------------------------------
	always_comb begin
		res_raw   = sum33[31:0];
		carry_vec = '0;
		case (op)
			ADD, ADC: carry_vec = cin_vec[32:1];
			// Borrow is the inverted carry
			SUB: carry_vec = ~cin_vec[32:1];
			AND: res_raw = a & b;
			OR:  res_raw = a | b;
			XOR: res_raw = a ^ b;
			SHL: begin
				res_raw = {a[30:0], 1'b0};
				// Shifted out bit lands on each size MSB
				carry_vec[7]  = a[7];
				carry_vec[15] = a[15];
				carry_vec[31] = a[31];
			end
			DAA: res_raw = {24'd0, al_adj};
			default: res_raw = sum33[31:0];
		endcase
	end

	// Zero extend to data size
	always_comb begin
		case (size)
			SIZE_8:  size_mask = 32'h0000_00ff;
			SIZE_16: size_mask = 32'h0000_ffff;
			default: size_mask = 32'hffff_ffff;
		endcase
	end

	assign result = res_raw & size_mask;

	// Flag side view
	assign af.a      = a;
	assign af.b      = b;
	assign af.op     = op;
	assign af.size   = size;
	assign af.result = res_raw;
	assign af.carry  = carry_vec;
	assign af.daa_cf = hi_adj;
	assign af.daa_af = lo_adj;

endmodule

`default_nettype wire

// File: design/alu_flag_if.sv
//--------------------------------------------------------------------
// Bundle from the datapath to the flag generator
//--------------------------------------------------------------------
`default_nettype none

interface alu_flag_if;
	import x86_alu_pkg::*;

	// Operands as seen by the datapath
	logic [31:0] a;
	logic [31:0] b;
	// Unmasked result
	logic [31:0] result;
	// Bit i holds the carry out of bit i
	logic [31:0] carry;
	alu_op_e     op;
	data_size_e  size;
	// DAA adjust decisions
	logic        daa_cf;
	logic        daa_af;

	modport alu_src (output a, b, result, carry, op, size, daa_cf, daa_af);
	modport flag_sink (input a, b, result, carry, op, size, daa_cf, daa_af);

endinterface

`default_nettype wire

// File: design/eflags_pkg.sv
//--------------------------------------------------------------------
// EFLAGS bit positions and arithmetic flag bundle
// Mask of the implemented EFLAGS bits
//--------------------------------------------------------------------
`default_nettype none

package eflags_pkg;

	// Positions inside the 32-bit EFLAGS word
	localparam int FLAG_CF = 0;
	localparam int FLAG_PF = 2;
	localparam int FLAG_AF = 4;
	localparam int FLAG_ZF = 6;
	localparam int FLAG_SF = 7;
	localparam int FLAG_DF = 10;
	localparam int FLAG_OF = 11;

	// Seven stored bits
	// Everything outside reads back as zero
	localparam logic [31:0] EFLAGS_MASK = (32'd1 << FLAG_CF) | (32'd1 << FLAG_PF) |
		(32'd1 << FLAG_AF) | (32'd1 << FLAG_ZF) | (32'd1 << FLAG_SF) |
		(32'd1 << FLAG_DF) | (32'd1 << FLAG_OF);

	// Flags produced by one operation
	// DF is never written by an operation so it is not part of this
	typedef struct packed {
		logic of;
		logic sf;
		logic zf;
		logic af;
		logic pf;
		logic cf;
	} arith_flags_t;

endpackage

`default_nettype wire

// File: design/x86_alu_pkg.sv
//--------------------------------------------------------------------
// Opcode and data size encodings of the execute unit
// Word address map of the Wishbone register block
//--------------------------------------------------------------------
`default_nettype none

package x86_alu_pkg;

	//----------------------------------------------------------------
	// Operations
	//----------------------------------------------------------------
	// ADD must stay at zero since reset leaves it in the command
	typedef enum logic [2:0] {
		ADD = 3'd0,
		ADC = 3'd1,
		SUB = 3'd2,
		AND = 3'd3,
		OR  = 3'd4,
		XOR = 3'd5,
		// Shift left by one only
		SHL = 3'd6,
		// Decimal adjust of AL after addition
		DAA = 3'd7
	} alu_op_e;

	// Operand width, code 3 reserved
	typedef enum logic [1:0] {
		SIZE_8  = 2'd0,
		SIZE_16 = 2'd1,
		SIZE_32 = 2'd2
	} data_size_e;

	//----------------------------------------------------------------
	// Register map, one 32-bit word per address
	//----------------------------------------------------------------
	typedef enum logic [2:0] {
		REG_OPA    = 3'd0,
		REG_OPB    = 3'd1,
		// Opcode in bits 2:0, size in bits 5:4
		REG_CMD    = 3'd2,
		// Read only
		REG_RESULT = 3'd3,
		REG_EFLAGS = 3'd4
	} reg_addr_e;

endpackage

`default_nettype wire
